//--- logic/monexp_config.svh
/* Exponentiation engine sizes */
`ifndef MONEXP_CONFIG_SVH
`define MONEXP_CONFIG_SVH

// operand geometry
`define WORD_WIDTH 16 // bits per word
`define NUM_WORDS 4 // words per operand

// full operand width
`define OPER_WIDTH (`WORD_WIDTH * `NUM_WORDS)

`endif

//--- logic/monexp_pkg.sv
/* Shared exponentiation types */
`default_nettype none
`include "monexp_config.svh"

package monexp_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t; // one datapath word
	typedef logic [`OPER_WIDTH-1:0] oper_t; // whole operand, lsw at bit 0

	// one word of every host operand per load cycle
	typedef struct packed {
		word_t m; // message
		word_t e; // exponent
		word_t n; // modulus
		word_t t; // R^2 mod n
		word_t r; // R mod n
	} load_word_t;

	// complete operand set after loading
	typedef struct packed {
		oper_t m;
		oper_t e;
		oper_t n;
		oper_t t;
		oper_t r;
		word_t n0prime; // -n^-1 mod 2^w
	} operand_set_t;

	// one Montgomery product request, a*b*R^-1
	typedef struct packed {
		oper_t a;
		oper_t b;
	} mont_req_t;

endpackage

`default_nettype wire

//--- logic/operand_loader.sv
/* Operand loader */
`timescale 1ns/1ps
`default_nettype none
`include "monexp_config.svh"

module operand_loader (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  logic idle,
	input  monexp_pkg::load_word_t in_word,
	input  monexp_pkg::word_t n0prime,
	output monexp_pkg::operand_set_t operands,
	output logic loaded
);
	localparam int CNT_W = $clog2(`NUM_WORDS);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(`NUM_WORDS - 1);

	logic loading; // word window open
	logic [CNT_W-1:0] cnt; // words taken so far
	logic accept;

	// loaded cycle is still covered, sequencer busy comes one cycle later
	assign accept = start && idle && !loading && !loaded;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			loading <= 1'b0;
			cnt <= '0;
			loaded <= 1'b0;
		end else begin
			loaded <= 1'b0; // single pulse
			if (loading) begin
				cnt <= cnt + 1'b1; // wraps back to zero
				if (cnt == LAST) begin
					loading <= 1'b0;
					loaded <= 1'b1;
				end
			end else if (accept) begin
				loading <= 1'b1;
				cnt <= '0;
			end
		end
	end

	// new word enters at the top, lsw ends up at the bottom
	always_ff @(posedge clk) begin
		if (accept)
			operands.n0prime <= n0prime; // sampled with start
		if (loading) begin
			operands.m <= {in_word.m, operands.m[`OPER_WIDTH-1:`WORD_WIDTH]};
			operands.e <= {in_word.e, operands.e[`OPER_WIDTH-1:`WORD_WIDTH]};
			operands.n <= {in_word.n, operands.n[`OPER_WIDTH-1:`WORD_WIDTH]};
			operands.t <= {in_word.t, operands.t[`OPER_WIDTH-1:`WORD_WIDTH]};
			operands.r <= {in_word.r, operands.r[`OPER_WIDTH-1:`WORD_WIDTH]};
		end
	end

	// Montgomery reduction needs an odd modulus
	a_n_odd: assert property (@(posedge clk) disable iff (reset) loaded |-> operands.n[0])
		else $error("modulus loaded even");

endmodule

`default_nettype wire

//--- logic/mont_product.sv
/* CIOS Montgomery product */
`timescale 1ns/1ps
`default_nettype none
`include "monexp_config.svh"

module mont_product (
	input  logic clk,
	input  logic reset,
	input  logic mont_start,
	input  monexp_pkg::mont_req_t req,
	input  monexp_pkg::oper_t modulus,
	input  monexp_pkg::word_t n0prime,
	output monexp_pkg::oper_t product,
	output logic done
);
	import monexp_pkg::*;

	localparam int IDX_W = $clog2(`NUM_WORDS);
	localparam logic [IDX_W-1:0] LAST = IDX_W'(`NUM_WORDS - 1);

	typedef enum logic [2:0] {
		PH_MUL, // v += a[i] * b
		PH_TOP, // fold carry into v[s], v[s+1]
		PH_M, // m = v[0] * n0prime
		PH_RED, // v = (v + m * n) >> w
		PH_FOLD1, // v[s-1] = v[s] + C
		PH_FOLD2 // v[s] = v[s+1] + C
	} phase_t;

	phase_t phase;
	logic running;
	logic store; // second cycle of a step
	logic [IDX_W-1:0] i; // outer word of a
	logic [IDX_W-1:0] j; // inner word
	word_t v [`NUM_WORDS + 2]; // accumulator, two spare top words
	word_t carry;
	word_t m_red; // reduction factor of this row
	word_t x_d, y_d, z_d, cin_d;
	word_t x_q, y_q, z_q, cin_q; // registered mac operands
	logic [2*`WORD_WIDTH-1:0] mac;

	// x*y + z + cin never exceeds two words
	assign mac = x_q * y_q + z_q + cin_q;

	always_comb begin
		x_d = '0;
		y_d = '0;
		z_d = '0;
		cin_d = '0;
		case (phase)
			PH_MUL: begin
				x_d = req.a[i*`WORD_WIDTH +: `WORD_WIDTH];
				y_d = req.b[j*`WORD_WIDTH +: `WORD_WIDTH];
				z_d = (i == '0) ? '0 : v[j]; // first row starts from zero
				cin_d = (j == '0) ? '0 : carry; // C = 0 per row
			end
			PH_TOP: begin
				z_d = v[`NUM_WORDS];
				cin_d = carry;
			end
			PH_M: begin
				x_d = v[0];
				y_d = n0prime; // only the low word is kept
			end
			PH_RED: begin
				x_d = m_red;
				y_d = modulus[j*`WORD_WIDTH +: `WORD_WIDTH];
				z_d = v[j];
				cin_d = (j == '0) ? '0 : carry;
			end
			PH_FOLD1: begin
				z_d = v[`NUM_WORDS];
				cin_d = carry;
			end
			PH_FOLD2: begin
				z_d = v[`NUM_WORDS + 1];
				cin_d = carry;
			end
			default: ;
		endcase
	end

	// issue cycle; also loads on the mont_start edge
	always_ff @(posedge clk) begin
		if (!store) begin
			x_q <= x_d;
			y_q <= y_d;
			z_q <= z_d;
			cin_q <= cin_d;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			running <= 1'b0;
			store <= 1'b0;
			phase <= PH_MUL;
			i <= '0;
			j <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (!running) begin
				if (mont_start) begin
					running <= 1'b1;
					store <= 1'b1; // first step issued on this edge
				end
			end else if (!store) begin
				store <= 1'b1;
			end else begin
				store <= 1'b0;
				case (phase)
					PH_MUL: begin
						j <= (j == LAST) ? '0 : j + 1'b1;
						if (j == LAST)
							phase <= PH_TOP;
					end
					PH_TOP: phase <= PH_M;
					PH_M: phase <= PH_RED;
					PH_RED: begin
						j <= (j == LAST) ? '0 : j + 1'b1;
						if (j == LAST)
							phase <= PH_FOLD1;
					end
					PH_FOLD1: phase <= PH_FOLD2;
					default: begin
						phase <= PH_MUL; // next outer word
						i <= (i == LAST) ? '0 : i + 1'b1;
						if (i == LAST) begin
							running <= 1'b0;
							done <= 1'b1;
						end
					end
				endcase
			end
		end
	end

	// store cycle
	always_ff @(posedge clk) begin
		if (mont_start && !running) begin
			for (int w = 0; w < `NUM_WORDS + 2; w++)
				v[w] <= '0; // fresh accumulator
		end else if (store) begin
			case (phase)
				PH_MUL: begin
					v[j] <= mac[`WORD_WIDTH-1:0];
					carry <= mac[2*`WORD_WIDTH-1:`WORD_WIDTH];
				end
				PH_TOP: begin
					v[`NUM_WORDS] <= mac[`WORD_WIDTH-1:0];
					v[`NUM_WORDS + 1] <= mac[2*`WORD_WIDTH-1:`WORD_WIDTH];
				end
				PH_M: m_red <= mac[`WORD_WIDTH-1:0];
				PH_RED: begin
					if (j != '0)
						v[j - 1'b1] <= mac[`WORD_WIDTH-1:0]; // shifted down one word
					carry <= mac[2*`WORD_WIDTH-1:`WORD_WIDTH];
				end
				PH_FOLD1: begin
					v[`NUM_WORDS - 1] <= mac[`WORD_WIDTH-1:0];
					carry <= mac[2*`WORD_WIDTH-1:`WORD_WIDTH];
				end
				default: v[`NUM_WORDS] <= mac[`WORD_WIDTH-1:0];
			endcase
		end
	end

	// no final subtraction, result stays below 2n
	always_comb begin
		for (int w = 0; w < `NUM_WORDS; w++)
			product[w*`WORD_WIDTH +: `WORD_WIDTH] = v[w];
	end

	// sequencer keeps one product in flight
	a_no_overlap: assert property (@(posedge clk) disable iff (reset) running |-> !mont_start)
		else $error("mont_start during running product");

endmodule

`default_nettype wire

//--- logic/exp_sequencer.sv
/* Exponent scan sequencer */
`timescale 1ns/1ps
`default_nettype none
`include "monexp_config.svh"

module exp_sequencer (
	input  logic clk,
	input  logic reset,
	input  logic loaded,
	input  monexp_pkg::operand_set_t operands,
	output logic mont_start,
	output monexp_pkg::mont_req_t req,
	input  monexp_pkg::oper_t product,
	input  logic mont_done,
	output logic result_ready,
	output monexp_pkg::oper_t result,
	output logic busy
);
	import monexp_pkg::*;

	localparam int BIT_W = $clog2(`OPER_WIDTH);
	localparam oper_t MONT_ONE = oper_t'(1); // plain 1 leaves the Montgomery domain

	typedef enum logic [2:0] {ST_IDLE, ST_MBAR, ST_SCAN, ST_SQR, ST_MUL, ST_FINAL} state_t;

	state_t state;
	logic [BIT_W-1:0] bit_idx; // exponent bit in work
	oper_t m_bar, c_bar;
	logic cur_bit, last_bit;
	logic issue; // start a product next cycle
	mont_req_t next_req;

	assign cur_bit = operands.e[bit_idx];
	assign last_bit = (bit_idx == '0);

	always_comb begin
		issue = 1'b0;
		next_req = '{a: product, b: product}; // square of the fresh c_bar
		case (state)
			ST_IDLE: begin
				issue = loaded;
				next_req = '{a: operands.m, b: operands.t}; // m_bar
			end
			ST_SCAN: begin
				issue = cur_bit; // first one bit found
				next_req = '{a: c_bar, b: c_bar};
			end
			ST_SQR: begin
				issue = mont_done;
				if (cur_bit)
					next_req = '{a: product, b: m_bar};
				else if (last_bit)
					next_req = '{a: product, b: MONT_ONE};
			end
			ST_MUL: begin
				issue = mont_done;
				if (last_bit)
					next_req = '{a: product, b: MONT_ONE};
			end
			default: ;
		endcase
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= ST_IDLE;
			bit_idx <= '0;
			mont_start <= 1'b0;
			result_ready <= 1'b0;
			busy <= 1'b0;
		end else begin
			mont_start <= issue;
			result_ready <= 1'b0;
			if (result_ready)
				busy <= 1'b0; // unloader raises unloading on this edge
			case (state)
				ST_IDLE: if (loaded) begin
					state <= ST_MBAR;
					bit_idx <= BIT_W'(`OPER_WIDTH - 1); // scan from the msb
					busy <= 1'b1;
				end
				ST_MBAR: if (mont_done)
					state <= ST_SCAN;
				ST_SCAN: begin
					if (cur_bit)
						state <= ST_SQR;
					else
						bit_idx <= bit_idx - 1'b1; // skip leading zero
				end
				ST_SQR: if (mont_done) begin
					if (cur_bit)
						state <= ST_MUL;
					else if (last_bit)
						state <= ST_FINAL;
					else
						bit_idx <= bit_idx - 1'b1;
				end
				ST_MUL: if (mont_done) begin
					if (last_bit)
						state <= ST_FINAL;
					else begin
						state <= ST_SQR;
						bit_idx <= bit_idx - 1'b1;
					end
				end
				default: if (mont_done) begin
					state <= ST_IDLE;
					result_ready <= 1'b1;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (issue)
			req <= next_req; // held until done
		if (state == ST_IDLE && loaded)
			c_bar <= operands.r; // 1 in Montgomery form
		if (mont_done) begin
			if (state == ST_MBAR)
				m_bar <= product;
			if (state == ST_SQR || state == ST_MUL)
				c_bar <= product;
			if (state == ST_FINAL)
				result <= product;
		end
	end

	// a zero exponent would never leave the scan
	a_e_nonzero: assert property (@(posedge clk) disable iff (reset)
		loaded |-> operands.e != '0)
		else $error("zero exponent loaded");

endmodule

`default_nettype wire

//--- logic/result_unloader.sv
/* Result unloader */
`timescale 1ns/1ps
`default_nettype none
`include "monexp_config.svh"

module result_unloader (
	input  logic clk,
	input  logic reset,
	input  logic result_ready,
	input  monexp_pkg::oper_t result,
	output monexp_pkg::word_t res_word,
	output logic res_valid,
	output logic unloading
);
	import monexp_pkg::*;

	localparam int CNT_W = $clog2(`NUM_WORDS);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(`NUM_WORDS - 1);

	oper_t shift_q; // lsw at the bottom
	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			unloading <= 1'b0;
			cnt <= '0;
		end else if (unloading) begin
			cnt <= cnt + 1'b1;
			if (cnt == LAST)
				unloading <= 1'b0; // last word out
		end else if (result_ready) begin
			unloading <= 1'b1;
			cnt <= '0;
		end
	end

	always_ff @(posedge clk) begin
		if (unloading)
			shift_q <= shift_q >> `WORD_WIDTH; // next word down
		else if (result_ready)
			shift_q <= result;
	end

	assign res_valid = unloading;
	assign res_word = unloading ? shift_q[`WORD_WIDTH-1:0] : '0; // zero when idle

endmodule

`default_nettype wire

//--- logic/monexp_top.sv
/* Montgomery exponentiation top */
`timescale 1ns/1ps
`default_nettype none

module monexp_top (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  monexp_pkg::load_word_t in_word,
	input  monexp_pkg::word_t n0prime,
	output logic busy,
	output monexp_pkg::word_t res_word,
	output logic res_valid
);
	import monexp_pkg::*;

	operand_set_t operands;
	mont_req_t req;
	oper_t product;
	oper_t result;
	logic loaded;
	logic mont_start;
	logic mont_done;
	logic result_ready;
	logic seq_busy;
	logic unloading;

	assign busy = seq_busy | unloading; // covers compute and unload

	operand_loader u_loader (
		.clk(clk),
		.reset(reset),
		.start(start),
		.idle(!busy), // start ignored while running
		.in_word(in_word),
		.n0prime(n0prime),
		.operands(operands),
		.loaded(loaded)
	);

	exp_sequencer u_seq (
		.clk(clk),
		.reset(reset),
		.loaded(loaded),
		.operands(operands),
		.mont_start(mont_start),
		.req(req),
		.product(product),
		.mont_done(mont_done),
		.result_ready(result_ready),
		.result(result),
		.busy(seq_busy)
	);

	mont_product u_mont (
		.clk(clk),
		.reset(reset),
		.mont_start(mont_start),
		.req(req),
		.modulus(operands.n),
		.n0prime(operands.n0prime),
		.product(product),
		.done(mont_done)
	);

	result_unloader u_unload (
		.clk(clk),
		.reset(reset),
		.result_ready(result_ready),
		.result(result),
		.res_word(res_word),
		.res_valid(res_valid),
		.unloading(unloading)
	);

endmodule

`default_nettype wire

//--- sim/monexp_ref.svh
/* Reference arithmetic */
`ifndef MONEXP_REF_SVH
`define MONEXP_REF_SVH

typedef logic [2*`OPER_WIDTH-1:0] wide_t; // room for a full product

// a*b mod n on a double width product
function automatic oper_t mod_mul(input oper_t a, input oper_t b, input oper_t n);
	wide_t prod;
	prod = wide_t'(a) * wide_t'(b);
	return oper_t'(prod % wide_t'(n));
endfunction

// right to left binary method, independent of the engine's scan order
function automatic oper_t mod_exp(input oper_t m, input oper_t e, input oper_t n);
	oper_t acc;
	oper_t base;
	acc = oper_t'(1) % n;
	base = m % n;
	for (int k = 0; k < `OPER_WIDTH; k++) begin
		if (e[k])
			acc = mod_mul(acc, base, n);
		base = mod_mul(base, base, n);
	end
	return acc;
endfunction

// -n^-1 mod 2^w, Newton step doubles the good bits
function automatic word_t neg_inverse_word(input oper_t n);
	word_t n0;
	word_t inv;
	n0 = n[`WORD_WIDTH-1:0];
	inv = word_t'(1); // exact to one bit for odd n
	for (int k = 0; k < $clog2(`WORD_WIDTH); k++)
		inv = inv * (word_t'(2) - n0 * inv); // wraps mod 2^w
	return -inv;
endfunction

// R mod n with R = 2^(w*s)
function automatic oper_t radix_mod(input oper_t n);
	wide_t big_r;
	big_r = wide_t'(1) << `OPER_WIDTH;
	return oper_t'(big_r % wide_t'(n));
endfunction

`endif

//--- sim/tb_monexp.sv
/* Exponentiation testbench */
`timescale 1ns/1ps
`default_nettype none
`include "monexp_config.svh"

module tb_monexp;
	import monexp_pkg::*;

	`include "monexp_ref.svh"

	localparam int CLK_PERIOD = 4;
	localparam int SEED = 4754;
	localparam int NUM_ENTRIES = 6;
	localparam int PROD_CYCLES = `NUM_WORDS * (4 * `NUM_WORDS + 8); // one MonPro
	localparam int CYCLES_PER_ENTRY = (`OPER_WIDTH + 2) * PROD_CYCLES + 50;
	localparam int TIMEOUT_CYCLES = NUM_ENTRIES * CYCLES_PER_ENTRY + 10; // reset slack

	typedef struct packed {
		oper_t m;
		oper_t e;
		oper_t n;
		logic rand_m; // message drawn at run time
		logic poke; // extra start while busy
	} stim_t;

	typedef struct packed {
		oper_t t; // R^2 mod n
		oper_t r; // R mod n
		word_t n0p;
		oper_t expect_c; // m^e mod n
	} derived_t;

	logic clk;
	logic reset;
	logic start;
	load_word_t in_word;
	word_t n0prime;
	logic busy;
	word_t res_word;
	logic res_valid;

	stim_t stim [NUM_ENTRIES];
	derived_t derived [NUM_ENTRIES];

	monexp_top UUT (
		.clk(clk),
		.reset(reset),
		.start(start),
		.in_word(in_word),
		.n0prime(n0prime),
		.busy(busy),
		.res_word(res_word),
		.res_valid(res_valid)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input oper_t got, input oper_t expected);
		assert (got === expected)
		else begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, expected);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	function automatic stim_t make_stim(input oper_t m, input oper_t e, input oper_t n,
		input logic rand_m, input logic poke);
		stim_t s;
		s.m = m;
		s.e = e;
		s.n = n;
		s.rand_m = rand_m;
		s.poke = poke;
		return s;
	endfunction

	// moduli odd and below 2^62
	// exponents need at most 64 squares and multiplies
	task automatic fill_table();
		oper_t rnd;
		stim[0] = make_stim(64'h1234_5678_9ABC_DEF0, 64'h0000_0000_0001_0001,
			64'h3A5F_1C2D_9E4B_7713, 1'b0, 1'b0);
		stim[1] = make_stim(64'h2F00_0000_0000_1234, 64'h0000_0000_0000_0001,
			64'h3FFF_FFFF_FFFF_FFC5, 1'b0, 1'b0); // e = 1
		stim[2] = make_stim(64'h1ABC_DEF0_1234_5679, 64'h4000_0000_0000_0000,
			64'h2000_0000_0000_0001, 1'b0, 1'b0); // long squaring chain
		stim[3] = make_stim(64'h0, 64'h0000_0000_DEAD_BEEF,
			64'h1F3A_5C7E_9B0D_2E4F, 1'b1, 1'b1);
		stim[4] = make_stim(64'h0, 64'h0000_0000_0000_0003,
			64'h0000_0000_0000_00FB, 1'b1, 1'b0); // tiny modulus
		stim[5] = make_stim(64'h0, 64'h0000_0000_0000_FFFF,
			64'h0F0F_F0F0_1234_5679, 1'b1, 1'b1);
		for (int k = 0; k < NUM_ENTRIES; k++) begin
			if (stim[k].rand_m) begin
				rnd = {$urandom(), $urandom()};
				stim[k].m = rnd % stim[k].n; // keep m < n
			end
			derived[k].r = radix_mod(stim[k].n);
			derived[k].t = mod_mul(derived[k].r, derived[k].r, stim[k].n);
			derived[k].n0p = neg_inverse_word(stim[k].n);
			derived[k].expect_c = mod_exp(stim[k].m, stim[k].e, stim[k].n);
		end
	endtask

	task automatic apply_reset();
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("busy", busy, 0);
		check_value("res_valid", res_valid, 0);
		check_value("res_word", res_word, 0);
	endtask

	task automatic run_entry(input int k);
		oper_t got;
		@(posedge clk);
		start <= 1'b1;
		n0prime <= derived[k].n0p; // taken with start
		for (int w = 0; w < `NUM_WORDS; w++) begin
			@(posedge clk);
			start <= 1'b0;
			n0prime <= '0; // valid only in the start cycle
			in_word <= '{m: stim[k].m[w*`WORD_WIDTH +: `WORD_WIDTH],
				e: stim[k].e[w*`WORD_WIDTH +: `WORD_WIDTH],
				n: stim[k].n[w*`WORD_WIDTH +: `WORD_WIDTH],
				t: derived[k].t[w*`WORD_WIDTH +: `WORD_WIDTH],
				r: derived[k].r[w*`WORD_WIDTH +: `WORD_WIDTH]}; // lsw first
		end
		@(posedge clk);
		in_word <= '0;
		if (stim[k].poke) begin
			repeat (20) @(posedge clk); // well inside m_bar product
			@(negedge clk);
			check_value("busy", busy, 1);
			@(posedge clk);
			start <= 1'b1;
			in_word <= '1; // junk that must be dropped
			@(posedge clk);
			start <= 1'b0;
			in_word <= '0;
		end
		@(negedge clk);
		while (busy !== 1'b1)
			@(negedge clk); // busy follows the last operand word
		while (res_valid !== 1'b1) begin
			check_value("busy", busy, 1); // held up to the unload
			@(negedge clk); // watchdog bounds this
		end
		for (int w = 0; w < `NUM_WORDS; w++) begin
			check_value("res_valid", res_valid, 1);
			check_value("busy", busy, 1);
			got[w*`WORD_WIDTH +: `WORD_WIDTH] = res_word;
			@(negedge clk);
		end
		check_value("res_valid", res_valid, 0); // exactly NUM_WORDS strobes
		check_value("busy", busy, 0);
		if (got >= stim[k].n)
			got = got - stim[k].n; // no final subtraction in the engine
		check_value($sformatf("result[%0d]", k), got, derived[k].expect_c);
	endtask

	initial begin
		void'($urandom(SEED));
		reset = 1'b1;
		start = 1'b0;
		in_word = '0;
		n0prime = '0;
		fill_table();
		apply_reset();
		for (int k = 0; k < NUM_ENTRIES; k++)
			run_entry(k);
		$display("Finished with no errors");
		$finish;
	end

	// worst entry needs m_bar, 64 squares or multiplies and the exit product
	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("watchdog expired before all results were unloaded");
		$display("Finished with errors");
		$fatal(1);
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+logic
+incdir+sim
logic/monexp_pkg.sv
logic/operand_loader.sv
logic/mont_product.sv
logic/exp_sequencer.sv
logic/result_unloader.sv
logic/monexp_top.sv
sim/tb_monexp.sv

//--- run_sim.sh
#!/bin/sh
# builds and runs the exponentiation testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=run.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_monexp \
	-Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vtb_monexp > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1
